// File: dv/tb_frl_cmd_rx.sv
`timescale 1ns/100ps
`default_nettype none

`include "frl_cmd_macros.svh"

module tb_frl_cmd_rx;

   localparam int MAX_CYCLES = 3000;          // six tests need about 500 cycles
   localparam int NBYTES     = 80;
   localparam logic [1:0] TIE_MASK [6] = '{2'b11, 2'b01, 2'b11, 2'b11, 2'b10, 2'b11};

   logic                 clk;
   logic                 reset;
   logic                 enable;
   logic [7:0]           lane0_data;
   logic [7:0]           lane1_data;
   logic                 rd_en;
   logic [1:0]           con_p;
   logic [1:0]           con_n;
   logic [1:0]           lost;
   logic                 rd_valid;
   logic [15:0]          rd_data;
   logic [`FRL_LOG_AW:0] count;
   logic                 overflow;

   logic [7:0]  stream [2][NBYTES];           // lane bytes, msb sent first
   logic [1:0]  hit [2][NBYTES];              // 1 positive, 2 negative
   logic [3:0]  exp_con [MAX_CYCLES+8];       // {con_n, con_p} per cycle
   logic [15:0] exp_log [$];
   logic [15:0] pend_rec [2];
   logic        pend_valid [2];
   logic        last_lane;                    // lane of the last log write
   logic        locked [2];
   logic [2:0]  lock_off [2];
   bit          exp_ovf;                      // sticky, a record was dropped
   int          pend_byte;
   int          stamp_base;
   int          cyc;
   int          errors;
   int          test_errors;
   int          passed;
   int          failed;
   bit          checking;
   string       test_name;

   frl_cmd_rx dut
   (
      .clk        (clk),
      .reset      (reset),
      .enable     (enable),
      .lane0_data (lane0_data),
      .lane1_data (lane1_data),
      .rd_en      (rd_en),
      .con_p      (con_p),
      .con_n      (con_n),
      .lost       (lost),
      .rd_valid   (rd_valid),
      .rd_data    (rd_data),
      .count      (count),
      .overflow   (overflow)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////
   // pulse checks and cycle limit
   ////////////////////////////////////////////////////////////
   always @(posedge clk)
   begin
      if (checking)
      begin
         assert ({con_n, con_p} == exp_con[cyc])
         else
         begin
            errors++;
            $display("** Error %s: {con_n,con_p} expected %b actual %b at cycle %0d",
                     test_name, exp_con[cyc], {con_n, con_p}, cyc);
         end
      end
      cyc++;
      if (cyc >= MAX_CYCLES)
      begin
         $display("run stopped at the cycle limit of %0d, a test never finished", MAX_CYCLES);
         $display(">>> FAIL");
         $finish;
      end
   end

   assert property (@(posedge clk) disable iff (reset) (con_p & con_n) == 2'b00)
   else
   begin
      errors++;
      $display("%s: a lane pulsed con_p and con_n together", test_name);
   end

   assert property (@(posedge clk) disable iff (reset) lost == 2'b00)
   else
   begin
      errors++;
      $display("%s: a lane dropped a record", test_name);
   end

   ////////////////////////////////////////////////////////////
   // stream model
   ////////////////////////////////////////////////////////////
   function automatic void add_expected(input logic [15:0] rec);
      if (exp_log.size() < `FRL_LOG_DEPTH)
         exp_log.push_back(rec);
      else
      begin
         exp_ovf = 1'b1;                         // full log drops the rest
      end
   endfunction

   // records of one byte index, in round robin order
   task automatic flush_pending();
      if (pend_valid[0] && pend_valid[1])
      begin
         add_expected(pend_rec[int'(!last_lane)]);
         add_expected(pend_rec[int'(last_lane)]);
      end
      else
      begin
         for (int l = 0; l < 2; l++)
         begin
            if (pend_valid[l])
            begin
               add_expected(pend_rec[l]);
               last_lane = 1'(l);
            end
         end
      end
      pend_valid[0] = 1'b0;
      pend_valid[1] = 1'b0;
   endtask

   task automatic start_test(input string name);
      test_name   = name;
      test_errors = errors;
      stamp_base  = 0;
      pend_byte   = -1;
      for (int l = 0; l < 2; l++)
      begin
         pend_valid[l] = 1'b0;
         locked[l]     = 1'b0;
         lock_off[l]   = 3'd0;
         for (int k = 0; k < NBYTES; k++)
         begin
            stream[l][k] = 8'($urandom) & 8'h55;  // never two ones in a row
            hit[l][k]    = 2'd0;
         end
      end
   endtask

   task automatic put_pattern(input int lane, input int k, input int s,
                              input logic [7:0] pat, input bit report);
      int p;
      if (k != pend_byte)
         flush_pending();
      pend_byte = k;
      for (int i = -8; i < 16; i++)
      begin
         p = 8*k + s + i;                        // zero guard byte on each side
         stream[lane][p/8][7-p%8] = (i >= 0 && i < 8) ? pat[7-i] : 1'b0;
      end
      if (report && pat == `FRL_LOCK_PATTERN)
      begin
         if (!locked[lane] || lock_off[lane] != 3'(s))
         begin
            pend_rec[lane]   = {1'b1, 1'(lane), 3'(s), lock_off[lane], 8'(k - stamp_base)};
            pend_valid[lane] = 1'b1;
         end
         locked[lane]   = 1'b1;
         lock_off[lane] = 3'(s);
      end
      else if (report)
      begin
         hit[lane][k]     = (pat == `FRL_CON_N_PATTERN) ? 2'd2 : 2'd1;
         pend_rec[lane]   = {1'b0, 1'(lane), 1'(hit[lane][k] == 2'd2), 3'(s),
                             10'(k - stamp_base)};
         pend_valid[lane] = 1'b1;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // stimulus and log readback
   ////////////////////////////////////////////////////////////
   task automatic idle(input int n);
      repeat (n)
      begin
         @(posedge clk);
         #1;
         enable     = 1'b0;
         lane0_data = 8'h00;
         lane1_data = 8'h00;
      end
   endtask

   task automatic run_burst(input int n, input int gap);
      flush_pending();
      for (int k = 0; k < n; k++)
      begin
         if (k == 0 || k == gap)
            idle(2);                             // clears both detectors
         @(posedge clk);
         #1;
         enable     = 1'b1;
         lane0_data = stream[0][k];
         lane1_data = stream[1][k];
         for (int l = 0; l < 2; l++)
         begin
            exp_con[cyc+4][l]   = (hit[l][k] == 2'd1);
            exp_con[cyc+4][2+l] = (hit[l][k] == 2'd2);
         end
      end
      @(posedge clk);
      #1;
      lane0_data = 8'h00;
      lane1_data = 8'h00;
   endtask

   task automatic check_log();
      logic [15:0] want;
      int t;
      t = 0;
      while (int'(count) != exp_log.size() && t < 20)
      begin
         @(posedge clk);
         #1;
         t++;
      end
      assert (int'(count) == exp_log.size())
      else
      begin
         errors++;
         $display("** Error %s: count expected %0d actual %0d", test_name, exp_log.size(), count);
      end
      assert (overflow == exp_ovf)
      else
      begin
         errors++;
         $display("** Error %s: overflow expected %b actual %b", test_name, exp_ovf, overflow);
      end
      while (exp_log.size() > 0)
      begin
         want = exp_log.pop_front();
         @(posedge clk);
         #1;
         rd_en = 1'b1;
         @(posedge clk);
         #1;
         rd_en = 1'b0;
         t = 0;
         while (!rd_valid && t < 8)
         begin
            @(posedge clk);
            #1;
            t++;
         end
         assert (rd_valid)
         else
         begin
            errors++;
            $display("%s: a read of the log returned no data", test_name);
         end
         if (rd_valid)
         begin
            assert (rd_data == want)
            else
            begin
               errors++;
               $display("** Error %s: record expected %h actual %h", test_name, want, rd_data);
            end
         end
      end
   endtask

   task automatic end_test();
      if (errors == test_errors)
      begin
         passed++;
         $display("test %s: ok", test_name);
      end
      else
      begin
         failed++;
         $display("test %s: failed with %0d errors", test_name, errors - test_errors);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////////////////////////
   initial
   begin
      void'($urandom(49));
      reset      = 1'b1;
      enable     = 1'b0;
      lane0_data = 8'h00;
      lane1_data = 8'h00;
      rd_en      = 1'b0;
      cyc        = 0;
      errors     = 0;
      passed     = 0;
      failed     = 0;
      checking   = 1'b0;
      exp_ovf    = 1'b0;
      last_lane  = 1'b1;                         // lane 0 takes the first tie
      test_name  = "reset";
      for (int c = 0; c < MAX_CYCLES+8; c++)
         exp_con[c] = 4'b0000;
      repeat (3) @(posedge clk);
      #1;
      reset    = 1'b0;
      checking = 1'b1;

      start_test("con_p_offsets");
      for (int s = 0; s < 8; s++)
         put_pattern(0, 2 + 4*s, s, `FRL_CON_P_PATTERN, 1'b1);
      run_burst(36, -1);
      check_log();
      end_test();

      start_test("con_n_lane1");
      for (int i = 0; i < 3; i++)
         put_pattern(1, 3 + 6*i, $urandom % 8, `FRL_CON_N_PATTERN, 1'b1);
      run_burst(24, -1);
      check_log();
      end_test();

      start_test("lock_changes");
      put_pattern(0, 2, 3, `FRL_LOCK_PATTERN, 1'b1);
      put_pattern(0, 8, 3, `FRL_LOCK_PATTERN, 1'b1);   // same alignment, no record
      put_pattern(0, 14, 6, `FRL_LOCK_PATTERN, 1'b1);
      run_burst(20, -1);
      check_log();
      end_test();

      start_test("two_lane_arbitration");
      for (int i = 0; i < 6; i++)
      begin
         for (int l = 0; l < 2; l++)
         begin
            if (TIE_MASK[i][l])
               put_pattern(l, 2 + 5*i, $urandom % 8,
                           ($urandom % 2) ? `FRL_CON_N_PATTERN : `FRL_CON_P_PATTERN, 1'b1);
         end
      end
      run_burst(34, -1);
      check_log();
      end_test();

      start_test("enable_gap");
      put_pattern(0, 5, 4, `FRL_CON_P_PATTERN, 1'b0);   // split by the gap
      stamp_base = 6;
      put_pattern(0, 10, 2, `FRL_CON_N_PATTERN, 1'b1);
      run_burst(16, 6);
      check_log();
      end_test();

      start_test("log_overflow");
      for (int i = 0; i < 17; i++)
         put_pattern(0, 2 + 4*i, i % 8, `FRL_CON_P_PATTERN, 1'b1);
      run_burst(72, -1);
      check_log();
      end_test();

      $display("tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
      if (errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: frl_cmd_rx.f
+incdir+rtl
rtl/frl_cmd_pkg.sv
rtl/con_shift_detector.sv
rtl/event_log_arbiter.sv
rtl/event_log.sv
rtl/frl_cmd_rx.sv
dv/tb_frl_cmd_rx.sv

// File: rtl/con_shift_detector.sv
`timescale 1ns/100ps
`default_nettype none

`include "frl_cmd_macros.svh"

module con_shift_detector
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    enable,
   input  logic                    lane_id,
   input  logic [7:0]              data,
   input  logic                    grant,
   output logic                    con_p,
   output logic                    con_n,
   output logic                    req,
   output frl_cmd_pkg::log_entry_u entry,
   output logic                    lost
);

   logic [7:0]              data_reg1;
   logic [7:0]              data_reg2;
   logic [7:0]              data_reg3;
   logic [2:0]              fill;           // stage holds an enabled byte
   logic [9:0]              byte_count;
   logic [9:0]              stamp;
   logic [15:0]             window;
   logic [3:0]              p_find;
   logic [3:0]              n_find;
   logic [3:0]              l_find;
   logic                    p_hit;
   logic                    n_hit;
   logic                    lock_move;
   logic                    new_rec;
   logic                    slot_free;
   logic                    lock;
   logic [2:0]              lock_offset;
   frl_cmd_pkg::log_entry_u con_rec;
   frl_cmd_pkg::log_entry_u lock_rec;

   // returns {hit, offset}, lowest offset wins
   function automatic logic [3:0] find_offset(input logic [15:0] win, input logic [7:0] pat);
      logic [3:0] res;
      res = 4'h0;
      for (int s = 7; s >= 0; s--)
      begin
         if (win[15-s -: 8] == pat)
         begin
            res = {1'b1, 3'(s)};
         end
      end
      return res;
   endfunction

   ////////////////////////////////////////////////////////////
   // byte pipeline
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk)
   begin
      if (reset || !enable)
      begin
         data_reg1  <= 8'h00;
         data_reg2  <= 8'h00;
         data_reg3  <= 8'h00;
         fill       <= 3'b000;
         byte_count <= 10'd0;                // counts from enable rise
      end
      else
      begin
         data_reg1  <= data;
         data_reg2  <= data_reg1;
         data_reg3  <= data_reg2;
         fill       <= {fill[1:0], 1'b1};
         byte_count <= byte_count + 10'd1;
      end
   end

   ////////////////////////////////////////////////////////////
   // pattern search over the upper two bytes
   ////////////////////////////////////////////////////////////
   assign window    = {data_reg3, data_reg2};
   assign stamp     = byte_count - 10'd3;    // index of byte in data_reg3
   assign p_find    = find_offset(window, `FRL_CON_P_PATTERN);
   assign n_find    = find_offset(window, `FRL_CON_N_PATTERN);
   assign l_find    = find_offset(window, `FRL_LOCK_PATTERN);
   assign p_hit     = fill[2] & p_find[3];
   assign n_hit     = fill[2] & n_find[3];
   assign lock_move = fill[2] & l_find[3] & (!lock || (l_find[2:0] != lock_offset));
   assign new_rec   = p_hit | n_hit | lock_move;
   assign slot_free = !req || grant;         // pending one leaves this edge

   always_comb
   begin
      con_rec.con.kind     = `FRL_KIND_CON;
      con_rec.con.lane     = lane_id;
      con_rec.con.polarity = !p_hit;         // positive wins a tie
      con_rec.con.offset   = p_hit ? p_find[2:0] : n_find[2:0];
      con_rec.con.stamp    = stamp;

      lock_rec.lock.kind        = `FRL_KIND_LOCK;
      lock_rec.lock.lane        = lane_id;
      lock_rec.lock.new_offset  = l_find[2:0];
      lock_rec.lock.prev_offset = lock_offset;
      lock_rec.lock.stamp       = stamp[7:0];
   end

   ////////////////////////////////////////////////////////////
   // control pulses, lock state, holding register
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk)
   begin
      if (reset || !enable)
      begin
         con_p       <= 1'b0;
         con_n       <= 1'b0;
         req         <= 1'b0;
         lost        <= 1'b0;
         lock        <= 1'b0;
         lock_offset <= 3'd0;
      end
      else
      begin
         con_p <= p_hit;
         con_n <= n_hit;
         lost  <= 1'b0;
         if (grant)
         begin
            req <= 1'b0;
         end
         if (new_rec)
         begin
            if (slot_free)
            begin
               req <= 1'b1;
            end
            else
            begin
               lost <= 1'b1;                 // one record deep only
            end
         end
         if (lock_move)
         begin
            lock        <= 1'b1;
            lock_offset <= l_find[2:0];
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (enable && new_rec && slot_free)
      begin
         entry <= (p_hit || n_hit) ? con_rec : lock_rec;   // control over lock
      end
   end

endmodule

`default_nettype wire

// File: rtl/event_log.sv
`timescale 1ns/100ps
`default_nettype none

`include "frl_cmd_macros.svh"

module event_log
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    wr_en,
   input  frl_cmd_pkg::log_entry_u wr_data,
   input  logic                    rd_en,
   output logic                    rd_valid,
   output frl_cmd_pkg::log_entry_u rd_data,
   output logic [`FRL_LOG_AW:0]    count,
   output logic                    overflow
);

   frl_cmd_pkg::log_entry_u mem [`FRL_LOG_DEPTH];
   logic [`FRL_LOG_AW-1:0]  wr_ptr;
   logic [`FRL_LOG_AW-1:0]  rd_ptr;
   logic                    do_wr;
   logic                    do_rd;

   assign do_wr = wr_en && (count != (`FRL_LOG_AW+1)'(`FRL_LOG_DEPTH));   // full drops
   assign do_rd = rd_en && (count != '0);                                 // empty returns nothing

   ////////////////////////////////////////////////////////////
   // storage
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk)
   begin
      if (do_wr)
      begin
         mem[wr_ptr] <= wr_data;
      end
   end

   always_ff @(posedge clk)
   begin
      if (do_rd)
      begin
         rd_data <= mem[rd_ptr];             // oldest record
      end
   end

   ////////////////////////////////////////////////////////////
   // pointers, occupancy, overflow
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         rd_valid <= 1'b0;
         overflow <= 1'b0;
      end
      else
      begin
         rd_valid <= do_rd;
         if (do_wr)
         begin
            wr_ptr <= wr_ptr + 1'b1;         // wraps at depth
         end
         if (do_rd)
         begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         if (wr_en && !do_wr)
         begin
            overflow <= 1'b1;                // sticky until reset
         end
      end
   end

endmodule

`default_nettype wire

// File: rtl/event_log_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module event_log_arbiter
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    req0,
   input  frl_cmd_pkg::log_entry_u entry0,
   input  logic                    req1,
   input  frl_cmd_pkg::log_entry_u entry1,
   output logic                    grant0,
   output logic                    grant1,
   output logic                    wr_en,
   output frl_cmd_pkg::log_entry_u wr_data
);

   logic last_lane;                          // lane served by the last grant

   ////////////////////////////////////////////////////////////
   // round robin between the two lanes
   ////////////////////////////////////////////////////////////

   // on a tie the lane not served last goes first
   assign grant0 = req0 && (!req1 || last_lane);
   assign grant1 = req1 && (!req0 || !last_lane);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         last_lane <= 1'b1;                  // lane 0 wins first tie
      end
      else if (grant0 || grant1)
      begin
         last_lane <= grant1;
      end
   end

   ////////////////////////////////////////////////////////////
   // single write port
   ////////////////////////////////////////////////////////////
   assign wr_en   = grant0 || grant1;
   assign wr_data = grant1 ? entry1 : entry0;

endmodule

`default_nettype wire

// File: rtl/frl_cmd_macros.svh
`ifndef FRL_CMD_MACROS_SVH
`define FRL_CMD_MACROS_SVH

////////////////////////////////////////////////////////////
// link patterns, searched MSB first
////////////////////////////////////////////////////////////
`define FRL_CON_P_PATTERN 8'h5f   // positive control
`define FRL_CON_N_PATTERN 8'haf   // negative control
`define FRL_LOCK_PATTERN  8'hff   // alignment byte

////////////////////////////////////////////////////////////
// event log geometry and record kinds
////////////////////////////////////////////////////////////
`define FRL_LOG_DEPTH     16
`define FRL_LOG_AW        4
`define FRL_KIND_CON      1'b0
`define FRL_KIND_LOCK     1'b1

`endif

// File: rtl/frl_cmd_pkg.sv
`default_nettype none

package frl_cmd_pkg;

   // control hit record
   typedef struct packed {
      logic       kind;         // 0 for control
      logic       lane;
      logic       polarity;     // 1 = negative
      logic [2:0] offset;       // bit offset from msb of start byte
      logic [9:0] stamp;        // start byte index
   } con_event_s;

   // lock alignment change record
   typedef struct packed {
      logic       kind;         // 1 for lock
      logic       lane;
      logic [2:0] new_offset;
      logic [2:0] prev_offset;
      logic [7:0] stamp;        // low bits of byte index
   } lock_event_s;

   // one log word, decoded by kind
   typedef union packed {
      con_event_s  con;
      lock_event_s lock;
   } log_entry_u;

endpackage

`default_nettype wire

// File: rtl/frl_cmd_rx.sv
`timescale 1ns/100ps
`default_nettype none

`include "frl_cmd_macros.svh"

module frl_cmd_rx
(
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 enable,
   input  logic [7:0]           lane0_data,
   input  logic [7:0]           lane1_data,
   input  logic                 rd_en,
   output logic [1:0]           con_p,
   output logic [1:0]           con_n,
   output logic [1:0]           lost,
   output logic                 rd_valid,
   output logic [15:0]          rd_data,
   output logic [`FRL_LOG_AW:0] count,
   output logic                 overflow
);

   logic                    req0;
   logic                    req1;
   logic                    grant0;
   logic                    grant1;
   frl_cmd_pkg::log_entry_u entry0;
   frl_cmd_pkg::log_entry_u entry1;
   logic                    wr_en;
   frl_cmd_pkg::log_entry_u wr_data;

   ////////////////////////////////////////////////////////////
   // lane detectors
   ////////////////////////////////////////////////////////////
   con_shift_detector u_lane0
   (
      .clk     (clk),
      .reset   (reset),
      .enable  (enable),
      .lane_id (1'b0),
      .data    (lane0_data),
      .grant   (grant0),
      .con_p   (con_p[0]),
      .con_n   (con_n[0]),
      .req     (req0),
      .entry   (entry0),
      .lost    (lost[0])
   );

   con_shift_detector u_lane1
   (
      .clk     (clk),
      .reset   (reset),
      .enable  (enable),
      .lane_id (1'b1),
      .data    (lane1_data),
      .grant   (grant1),
      .con_p   (con_p[1]),
      .con_n   (con_n[1]),
      .req     (req1),
      .entry   (entry1),
      .lost    (lost[1])
   );

   ////////////////////////////////////////////////////////////
   // shared event memory
   ////////////////////////////////////////////////////////////
   event_log_arbiter u_arb
   (
      .clk     (clk),
      .reset   (reset),
      .req0    (req0),
      .entry0  (entry0),
      .req1    (req1),
      .entry1  (entry1),
      .grant0  (grant0),
      .grant1  (grant1),
      .wr_en   (wr_en),
      .wr_data (wr_data)
   );

   event_log u_log
   (
      .clk      (clk),
      .reset    (reset),
      .wr_en    (wr_en),
      .wr_data  (wr_data),
      .rd_en    (rd_en),
      .rd_valid (rd_valid),
      .rd_data  (rd_data),           // raw word out of the union
      .count    (count),
      .overflow (overflow)
   );

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# build and run the frl_cmd_rx testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timing -Wno-fatal \
   --top-module tb_frl_cmd_rx \
   -f frl_cmd_rx.f \
   -o sim_frl_cmd_rx

./obj_dir/sim_frl_cmd_rx | tee sim.log

if grep -q '^>>> PASS$' sim.log
then
   exit 0
else
   exit 1
fi
